// File: hw/valve_link_pkg.sv
package valve_link_pkg;

    // --------------------
    // Field widths
    // --------------------
    localparam int VC_W       = 16;                     // Capacitor voltage
    localparam int ST_W       = 20;                     // Status value
    localparam int RX_BYTE_W  = 8;                      // Command byte
    localparam int BYPASS_BIT = 4;                      // Bypass flag inside command byte

    // --------------------
    // Frame layout
    // --------------------
    localparam int   TX_DATA_W     = VC_W + ST_W;       // 36 payload bits, vc in the low part
    localparam int   TX_FRAME_BITS = TX_DATA_W + 3;     // Start, data, parity, stop
    localparam int   RX_FRAME_BITS = RX_BYTE_W + 3;
    localparam logic START_LVL     = 1'b1;              // Line idles low
    localparam logic STOP_LVL      = 1'b0;

    // Word sent per channel on each strobe
    typedef struct packed {
        logic [VC_W-1:0] vc;
        logic [ST_W-1:0] st;
    } link_word_t;

    // Fault injection controls, one set per channel
    typedef struct packed {
        logic lost_voltage;                             // Acts as channel reset
        logic temp_fault;                               // Optic over-temperature
        logic tx_fault;
        logic rx_fault;
    } fault_ctrl_t;

    // Per-channel report
    typedef struct packed {
        logic                 comm_err;                 // Receive silence
        logic                 verify_err;               // Parity or stop error
        logic                 bypass;
        logic                 tx_muted;
        logic [RX_BYTE_W-1:0] rx_byte;                  // Last good command byte
    } channel_status_t;

endpackage

// File: hw/frame_tx.sv
`timescale 1ns/1ns

module frame_tx #(
    parameter int BIT_DIV = 4
) (
    input  logic                       clk_sys,
    input  logic                       rst_i,
    input  logic                       start_i,
    input  valve_link_pkg::link_word_t word_i,
    output logic                       txd_o
);
    import valve_link_pkg::*;

    localparam int DIV_W = $clog2(BIT_DIV);
    localparam int CNT_W = $clog2(TX_FRAME_BITS);

    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(BIT_DIV - 1);
    localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(TX_FRAME_BITS - 1);

    logic [TX_DATA_W-1:0]     data;                     // vc in low bits, goes out first
    logic [TX_FRAME_BITS-2:0] shift_q;                  // Frame minus start bit
    logic [DIV_W-1:0]         div_cnt;
    logic [CNT_W-1:0]         bit_cnt;
    logic                     busy;

    assign data = {word_i.st, word_i.vc};

    // --------------------
    // Shift register
    // --------------------
    always_ff @(posedge clk_sys)
    begin
        if (rst_i)
        begin
            busy    <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= '0;
            txd_o   <= 1'b0;
        end
        else if (!busy)
        begin
            if (start_i)                                // Strobes while busy are dropped
            begin
                busy    <= 1'b1;
                div_cnt <= '0;
                bit_cnt <= '0;
                shift_q <= {STOP_LVL, ~^data, data};    // Odd parity over the data
                txd_o   <= START_LVL;                   // Start bit on the strobe edge
            end
        end
        else if (div_cnt == DIV_LAST)
        begin
            div_cnt <= '0;
            if (bit_cnt == BIT_LAST)
            begin
                busy  <= 1'b0;
                txd_o <= 1'b0;                          // Back to idle
            end
            else
            begin
                bit_cnt <= bit_cnt + 1'b1;
                txd_o   <= shift_q[0];
                shift_q <= shift_q >> 1;
            end
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

endmodule

// File: hw/frame_rx.sv
`timescale 1ns/1ns

module frame_rx #(
    parameter int BIT_DIV = 4
) (
    input  logic                                 clk_sys,
    input  logic                                 rst_i,
    input  logic                                 rxd_i,
    output logic                                 byte_valid_o,
    output logic [valve_link_pkg::RX_BYTE_W-1:0] byte_o,
    output logic                                 frame_err_o
);
    import valve_link_pkg::*;

    localparam int DIV_W = $clog2(BIT_DIV);
    localparam int BIT_W = $clog2(RX_FRAME_BITS);

    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(BIT_DIV - 1);
    localparam logic [DIV_W-1:0] DIV_MID  = DIV_W'(BIT_DIV / 2);     // Mid-bit sample point
    localparam logic [BIT_W-1:0] DATA_END = BIT_W'(RX_BYTE_W);       // Last data bit index
    localparam logic [BIT_W-1:0] STOP_IDX = BIT_W'(RX_FRAME_BITS - 1);

    logic                 rxd_q;                        // Previous line level
    logic                 busy;
    logic [DIV_W-1:0]     div_cnt;
    logic [BIT_W-1:0]     bit_cnt;                      // Index of next sample, 0 is start
    logic                 par_q;                        // XOR of data and parity bits
    logic [RX_BYTE_W-1:0] byte_q;
    logic                 sample_en;
    logic                 data_bit;
    logic                 frame_ok;

    assign sample_en = busy & (div_cnt == DIV_MID);
    assign data_bit  = (bit_cnt != '0) && (bit_cnt <= DATA_END);
    assign frame_ok  = par_q & (rxd_i == STOP_LVL);     // Valid at the stop sample only
    assign byte_o    = byte_q;

    // --------------------
    // Frame control
    // --------------------
    always_ff @(posedge clk_sys)
    begin
        if (rst_i)
        begin
            rxd_q        <= 1'b0;
            busy         <= 1'b0;
            div_cnt      <= '0;
            bit_cnt      <= '0;
            par_q        <= 1'b0;
            byte_valid_o <= 1'b0;
            frame_err_o  <= 1'b0;
        end
        else
        begin
            rxd_q        <= rxd_i;
            byte_valid_o <= 1'b0;                       // Single-cycle pulses
            frame_err_o  <= 1'b0;
            if (!busy)
            begin
                if (rxd_i && !rxd_q)                    // Rising edge of start bit
                begin
                    busy    <= 1'b1;
                    div_cnt <= DIV_W'(1);               // Edge cycle is cycle 0 of the bit
                    bit_cnt <= '0;
                    par_q   <= 1'b0;
                end
            end
            else
            begin
                div_cnt <= (div_cnt == DIV_LAST) ? '0 : div_cnt + 1'b1;
                if (sample_en)
                begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == STOP_IDX)
                    begin
                        busy         <= 1'b0;           // Wait for next rising edge
                        byte_valid_o <= frame_ok;
                        frame_err_o  <= ~frame_ok;
                    end
                    else if (bit_cnt != '0)
                    begin
                        par_q <= par_q ^ rxd_i;         // Data and parity bits
                    end
                end
            end
        end
    end

    // --------------------
    // Data shift
    // --------------------
    always_ff @(posedge clk_sys)
    begin
        if (sample_en && data_bit)
        begin
            byte_q <= {rxd_i, byte_q[RX_BYTE_W-1:1]};   // LSB arrives first
        end
    end

endmodule

// File: hw/link_health.sv
`timescale 1ns/1ns

module link_health #(
    parameter int RX_TIMEOUT = 400
) (
    input  logic                                 clk_sys,
    input  logic                                 rst_i,
    input  logic                                 byte_valid_i,
    input  logic [valve_link_pkg::RX_BYTE_W-1:0] byte_i,
    input  logic                                 frame_err_i,
    input  logic                                 tx_mute_i,
    output valve_link_pkg::channel_status_t      status_o
);
    import valve_link_pkg::*;

    localparam int               TMO_W    = $clog2(RX_TIMEOUT + 1);
    localparam logic [TMO_W-1:0] TMO_LAST = TMO_W'(RX_TIMEOUT - 1);

    logic [TMO_W-1:0]     silence_cnt;                  // Cycles since last good byte
    logic [RX_BYTE_W-1:0] rx_byte_q;
    logic                 verify_err_q;
    logic                 comm_err_q;
    logic                 tx_muted_q;

    always_ff @(posedge clk_sys)
    begin
        if (rst_i)
        begin
            silence_cnt  <= '0;
            rx_byte_q    <= '0;
            verify_err_q <= 1'b0;
            comm_err_q   <= 1'b0;
            tx_muted_q   <= 1'b0;
        end
        else
        begin
            tx_muted_q <= tx_mute_i;
            if (byte_valid_i)
            begin
                rx_byte_q    <= byte_i;
                verify_err_q <= 1'b0;
                comm_err_q   <= 1'b0;
                silence_cnt  <= '0;
            end
            else
            begin
                if (frame_err_i)
                begin
                    verify_err_q <= 1'b1;               // Keeps last good byte
                end
                if (silence_cnt == TMO_LAST)
                begin
                    comm_err_q <= 1'b1;                 // Sticky until next good byte
                end
                else
                begin
                    silence_cnt <= silence_cnt + 1'b1;
                end
            end
        end
    end

    // --------------------
    // Status word
    // --------------------
    assign status_o.comm_err   = comm_err_q;
    assign status_o.verify_err = verify_err_q;
    assign status_o.bypass     = rx_byte_q[BYPASS_BIT];
    assign status_o.tx_muted   = tx_muted_q;
    assign status_o.rx_byte    = rx_byte_q;

endmodule

// File: hw/link_channel.sv
`timescale 1ns/1ns

module link_channel #(
    parameter int BIT_DIV    = 4,
    parameter int RX_TIMEOUT = 400
) (
    input  logic                            clk_sys,
    input  logic                            rst_i,
    input  logic                            trans_start_i,
    input  valve_link_pkg::link_word_t      word_i,
    input  valve_link_pkg::fault_ctrl_t     fault_ctrl_i,
    input  logic                            phy_rxd_i,
    output logic                            phy_txd_o,
    output valve_link_pkg::channel_status_t status_o
);
    import valve_link_pkg::*;

    logic                 ch_rst;                       // Board reset or lost voltage
    logic                 tx_mute;
    logic                 rx_block;
    logic                 tx_raw;                       // Serializer output before muting
    logic                 rx_line;                      // Receive line after blocking
    logic                 byte_valid;
    logic                 frame_err;
    logic [RX_BYTE_W-1:0] rx_byte;

    // --------------------
    // Fault injection
    // --------------------
    assign ch_rst   = rst_i | fault_ctrl_i.lost_voltage;
    assign tx_mute  = fault_ctrl_i.temp_fault | fault_ctrl_i.tx_fault;
    assign rx_block = fault_ctrl_i.rx_fault;

    assign phy_txd_o = tx_raw & ~tx_mute;               // Serializer keeps running while muted
    assign rx_line   = phy_rxd_i & ~rx_block;           // Blocked line looks idle

    // --------------------
    // Transmit path
    // --------------------
    frame_tx #(
        .BIT_DIV      (BIT_DIV)
    ) i_frame_tx (
        .clk_sys      (clk_sys),
        .rst_i        (ch_rst),
        .start_i      (trans_start_i),
        .word_i       (word_i),
        .txd_o        (tx_raw)
    );

    // --------------------
    // Receive path
    // --------------------
    frame_rx #(
        .BIT_DIV      (BIT_DIV)
    ) i_frame_rx (
        .clk_sys      (clk_sys),
        .rst_i        (ch_rst),
        .rxd_i        (rx_line),
        .byte_valid_o (byte_valid),
        .byte_o       (rx_byte),
        .frame_err_o  (frame_err)
    );

    // Status fields cleared together with the link on lost voltage
    link_health #(
        .RX_TIMEOUT   (RX_TIMEOUT)
    ) i_link_health (
        .clk_sys      (clk_sys),
        .rst_i        (ch_rst),
        .byte_valid_i (byte_valid),
        .byte_i       (rx_byte),
        .frame_err_i  (frame_err),
        .tx_mute_i    (tx_mute),
        .status_o     (status_o)
    );

endmodule

// File: hw/valve_link_top.sv
`timescale 1ns/1ns

module valve_link_top #(
    parameter int CH_NUM     = 4,
    parameter int BIT_DIV    = 4,                       // Cycles per serial bit, at least 2
    parameter int RX_TIMEOUT = 400                      // Silence limit in cycles
) (
    input  logic                                         clk_sys,
    input  logic                                         rst_i,
    input  logic                                         trans_start_i,     // Shared send strobe
    input  valve_link_pkg::link_word_t      [CH_NUM-1:0] tx_word_i,
    input  valve_link_pkg::fault_ctrl_t     [CH_NUM-1:0] fault_ctrl_i,
    input  logic                                         dbg_sel_i,
    input  valve_link_pkg::link_word_t                   dbg_word_i,
    input  logic                            [CH_NUM-1:0] phy_rxd_i,
    output logic                            [CH_NUM-1:0] phy_txd_o,
    output valve_link_pkg::channel_status_t [CH_NUM-1:0] status_o
);
    import valve_link_pkg::*;

    link_word_t [CH_NUM-1:0] ch_word;                   // Word after debug select

    // --------------------
    // Debug override
    // --------------------
    always_comb
    begin
        ch_word = tx_word_i;
        if (dbg_sel_i)
        begin
            ch_word[0] = dbg_word_i;                    // Channel 0 only
        end
    end

    // --------------------
    // Channel array
    // --------------------
    // Every channel sees the same strobe, so all frames start on the same edge
    for (genvar ch = 0; ch < CH_NUM; ch++)
    begin : g_channel
        link_channel #(
            .BIT_DIV       (BIT_DIV),
            .RX_TIMEOUT    (RX_TIMEOUT)
        ) i_link_channel (
            .clk_sys       (clk_sys),
            .rst_i         (rst_i),
            .trans_start_i (trans_start_i),
            .word_i        (ch_word[ch]),
            .fault_ctrl_i  (fault_ctrl_i[ch]),
            .phy_rxd_i     (phy_rxd_i[ch]),
            .phy_txd_o     (phy_txd_o[ch]),
            .status_o      (status_o[ch])
        );
    end

endmodule

// File: include/valve_link_tb_model.svh
`ifndef VALVE_LINK_TB_MODEL_SVH
`define VALVE_LINK_TB_MODEL_SVH

// The including module provides clk_sys, phy_rxd, phy_txd and BIT_DIV

// --------------------
// Random source
// --------------------
function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

function automatic valve_link_pkg::link_word_t rand_word(inout logic [31:0] state);
    valve_link_pkg::link_word_t word;
    state   = lcg_next(state);
    word.vc = state[31:16];
    state   = lcg_next(state);
    word.st = state[31:12];
    return word;
endfunction

// --------------------
// Receive side stimulus
// --------------------
// Drives one command frame, bad_par flips parity and bad_stop sends a stop of 1
task automatic send_rx_frame(
    input int         ch,
    input logic [7:0] data,
    input logic       bad_par,
    input logic       bad_stop
);
    logic [valve_link_pkg::RX_FRAME_BITS-1:0] frame;
    frame = {valve_link_pkg::STOP_LVL ^ bad_stop, (~^data) ^ bad_par, data,
             valve_link_pkg::START_LVL};
    @(negedge clk_sys);
    for (int b = 0; b < valve_link_pkg::RX_FRAME_BITS; b++)
    begin
        phy_rxd[ch] = frame[b];
        repeat (BIT_DIV) @(negedge clk_sys);
    end
    phy_rxd[ch] = 1'b0;                                 // Idle
endtask

// --------------------
// Transmit side decode
// --------------------
// Waits for the start bit and samples every bit near its middle
task automatic recv_tx_frame(
    input  int                         ch,
    output valve_link_pkg::link_word_t word,
    output logic                       start_ok,
    output logic                       par_ok,
    output logic                       stop_ok
);
    logic [valve_link_pkg::TX_FRAME_BITS-1:0] frame;
    @(posedge phy_txd[ch]);
    repeat (BIT_DIV / 2) @(negedge clk_sys);
    for (int b = 0; b < valve_link_pkg::TX_FRAME_BITS; b++)
    begin
        frame[b] = phy_txd[ch];
        if (b < valve_link_pkg::TX_FRAME_BITS - 1)
        begin
            repeat (BIT_DIV) @(negedge clk_sys);
        end
    end
    word.vc  = frame[valve_link_pkg::VC_W:1];
    word.st  = frame[valve_link_pkg::TX_DATA_W:valve_link_pkg::VC_W + 1];
    start_ok = (frame[0] == valve_link_pkg::START_LVL);
    par_ok   = ^frame[valve_link_pkg::TX_DATA_W + 1:1]; // Odd count of ones
    stop_ok  = (frame[valve_link_pkg::TX_FRAME_BITS - 1] == valve_link_pkg::STOP_LVL);
endtask

`endif

// File: tests/valve_link_tb.sv
`timescale 1ns/1ns

module valve_link_tb;
    import valve_link_pkg::*;

    localparam int CH_NUM      = 4;
    localparam int BIT_DIV     = 4;
    localparam int RX_TIMEOUT  = 400;
    localparam int CLK_PERIOD  = 40;
    localparam int FRAME_CYC   = TX_FRAME_BITS * BIT_DIV + BIT_DIV;   // Frame plus one bit
    localparam int NUM_TESTS   = 6;
    localparam int WATCHDOG_NS = (12 * FRAME_CYC * NUM_TESTS + 1000) * CLK_PERIOD;

    logic                               clk_sys = 1'b0;
    logic                               rst_i;
    logic                               trans_start;
    link_word_t      [CH_NUM-1:0]       tx_word;
    fault_ctrl_t     [CH_NUM-1:0]       fault_ctrl;
    logic                               dbg_sel;
    link_word_t                         dbg_word;
    logic            [CH_NUM-1:0]       phy_rxd;
    logic            [CH_NUM-1:0]       phy_txd;
    channel_status_t [CH_NUM-1:0]       status;

    logic [CH_NUM-1:0] mute_vec;                        // Temp or tx fault per channel
    logic [CH_NUM-1:0] lost_vec;
    logic [CH_NUM-1:0] muted_vec;                       // Reported tx_muted
    logic [CH_NUM-1:0] stat_nz;                         // Any status bit set
    logic [CH_NUM-1:0][RX_BYTE_W-1:0] good_byte;        // Last good byte sent per channel
    logic [31:0]       seed = 32'hdd4c_cfd4;
    int                imm_errors = 0;
    int                conc_errors = 0;

    `include "valve_link_tb_model.svh"

    always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

    valve_link_top #(
        .CH_NUM        (CH_NUM),
        .BIT_DIV       (BIT_DIV),
        .RX_TIMEOUT    (RX_TIMEOUT)
    ) i_valve_link_top (
        .clk_sys       (clk_sys),
        .rst_i         (rst_i),
        .trans_start_i (trans_start),
        .tx_word_i     (tx_word),
        .fault_ctrl_i  (fault_ctrl),
        .dbg_sel_i     (dbg_sel),
        .dbg_word_i    (dbg_word),
        .phy_rxd_i     (phy_rxd),
        .phy_txd_o     (phy_txd),
        .status_o      (status)
    );

    // --------------------
    // Concurrent checks
    // --------------------
    always_comb
    begin
        for (int c = 0; c < CH_NUM; c++)
        begin
            mute_vec[c]  = fault_ctrl[c].temp_fault | fault_ctrl[c].tx_fault;
            lost_vec[c]  = fault_ctrl[c].lost_voltage;
            muted_vec[c] = status[c].tx_muted;
            stat_nz[c]   = |status[c];
        end
    end

    assert property (@(posedge clk_sys) disable iff (rst_i) (mute_vec & phy_txd) == '0)
    else
    begin
        conc_errors++;
        $display("CHECK FAILED at %0t ns: line active while muted, txd %b", $time, phy_txd);
    end

    // Lost voltage resets the channel on the edge that sees it
    assert property (@(posedge clk_sys) disable iff (rst_i)
        ($past(lost_vec) & (phy_txd | stat_nz)) == '0)
    else
    begin
        conc_errors++;
        $display("CHECK FAILED at %0t ns: channel not cleared by lost voltage", $time);
    end

    // One register behind the fault controls, held low by lost voltage
    assert property (@(posedge clk_sys) disable iff (rst_i)
        muted_vec == $past(mute_vec & ~lost_vec))
    else
    begin
        conc_errors++;
        $display("CHECK FAILED at %0t ns: tx_muted %b does not follow the faults",
                 $time, muted_vec);
    end

    // --------------------
    // Test tasks
    // --------------------
    task automatic check_true(input logic cond, input string msg);
        assert (cond)
        else
        begin
            imm_errors++;
            $display("CHECK FAILED at %0t ns: %s", $time, msg);
        end
    endtask

    task automatic decode_channel(input int ch, input link_word_t exp, input logic mute);
        link_word_t got;
        logic       start_ok;
        logic       par_ok;
        logic       stop_ok;
        if (mute)
        begin
            repeat (FRAME_CYC) @(negedge clk_sys);      // Line stays low, watched above
        end
        else
        begin
            recv_tx_frame(ch, got, start_ok, par_ok, stop_ok);
            check_true(got == exp, $sformatf("ch%0d word %h, expected %h", ch, got, exp));
            check_true(start_ok && par_ok && stop_ok,
                       $sformatf("ch%0d framing start %b parity %b stop %b",
                                 ch, start_ok, par_ok, stop_ok));
        end
    endtask

    task automatic send_words(input logic [CH_NUM-1:0] muted);
        link_word_t [CH_NUM-1:0] exp;
        @(negedge clk_sys);
        for (int c = 0; c < CH_NUM; c++)
        begin
            tx_word[c] = rand_word(seed);
            exp[c]     = tx_word[c];
        end
        if (dbg_sel)
        begin
            dbg_word = rand_word(seed);
            exp[0]   = dbg_word;                        // Channel 0 sends the debug word
        end
        trans_start = 1'b1;
        fork
            decode_channel(0, exp[0], muted[0]);
            decode_channel(1, exp[1], muted[1]);
            decode_channel(2, exp[2], muted[2]);
            decode_channel(3, exp[3], muted[3]);
            begin
                @(negedge clk_sys);
                trans_start = 1'b0;
                check_true(phy_txd == ~muted,
                           $sformatf("start bit txd %b, expected %b", phy_txd, ~muted));
            end
        join
        repeat (BIT_DIV) @(negedge clk_sys);
    endtask

    task automatic check_rx_byte(input int ch, input logic bad_par, input logic bad_stop);
        logic [7:0] data;
        seed = lcg_next(seed);
        data = seed[31:24];
        send_rx_frame(ch, data, bad_par, bad_stop);
        repeat (2 * BIT_DIV) @(negedge clk_sys);
        if (bad_par || bad_stop)
        begin
            check_true(status[ch].verify_err, $sformatf("ch%0d bad frame not flagged", ch));
            check_true(status[ch].rx_byte == good_byte[ch],
                       $sformatf("ch%0d byte %h, expected %h",
                                 ch, status[ch].rx_byte, good_byte[ch]));
        end
        else
        begin
            good_byte[ch] = data;
            check_true(status[ch].rx_byte == data, $sformatf("ch%0d byte %h, expected %h",
                                                             ch, status[ch].rx_byte, data));
            check_true(status[ch].bypass == data[4], $sformatf("ch%0d bypass wrong", ch));
            check_true(!status[ch].verify_err && !status[ch].comm_err,
                       $sformatf("ch%0d error flags %b%b after good byte", ch,
                                 status[ch].verify_err, status[ch].comm_err));
        end
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial
    begin
        rst_i       = 1'b1;
        trans_start = 1'b0;
        tx_word     = '0;
        fault_ctrl  = '0;
        dbg_sel     = 1'b0;
        dbg_word    = '0;
        phy_rxd     = '0;
        good_byte   = '0;
        repeat (2) @(negedge clk_sys);
        rst_i = 1'b0;

        send_words('0);
        fault_ctrl[1].temp_fault = 1'b1;
        fault_ctrl[2].tx_fault   = 1'b1;
        send_words(4'b0110);
        fault_ctrl = '0;

        for (int c = 0; c < CH_NUM; c++)
        begin
            check_rx_byte(c, 1'b0, 1'b0);
        end
        check_rx_byte(1, 1'b1, 1'b0);                   // Wrong parity
        check_rx_byte(1, 1'b0, 1'b0);
        check_rx_byte(2, 1'b0, 1'b1);                   // Stop bit of 1
        check_rx_byte(2, 1'b0, 1'b0);

        repeat (RX_TIMEOUT + 2 * BIT_DIV) @(negedge clk_sys);
        for (int c = 0; c < CH_NUM; c++)
        begin
            check_true(status[c].comm_err, $sformatf("ch%0d silence not reported", c));
        end

        check_rx_byte(2, 1'b0, 1'b0);
        fault_ctrl[2].rx_fault = 1'b1;
        repeat (RX_TIMEOUT / (RX_FRAME_BITS * BIT_DIV) + 2) send_rx_frame(2, 8'h5a, 1'b0, 1'b0);
        check_true(status[2].comm_err, "ch2 blocked receive not reported");
        fault_ctrl = '0;
        check_rx_byte(2, 1'b0, 1'b0);

        dbg_sel                    = 1'b1;
        fault_ctrl[3].lost_voltage = 1'b1;
        send_words(4'b1000);
        check_true(status[3] == '0, $sformatf("ch3 status %h under lost voltage", status[3]));

        $display("Errors: %0d in immediate checks, %0d in concurrent checks",
                 imm_errors, conc_errors);
        if (imm_errors + conc_errors == 0)
        begin
            $display(">>> PASS");
        end
        else
        begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Simulation hung: tests did not finish within %0d ns", WATCHDOG_NS);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// File: valve_link.f
+incdir+include
hw/valve_link_pkg.sv
hw/frame_tx.sv
hw/frame_rx.sv
hw/link_health.sv
hw/link_channel.sv
hw/valve_link_top.sv
tests/valve_link_tb.sv

// File: run_sim.sh
#!/bin/sh
verilator --binary --timing --assert -j 0 --top-module valve_link_tb \
    -f valve_link.f -o valve_link_sim \
    && ./obj_dir/valve_link_sim > sim.log \
    || { echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -q ">>> PASS" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
